//--- source/jtag_pkg.sv
// Opcodes are IR_LEN wide and any code not listed decodes as BYPASS; bsr_t grows with NUM_PINS
package jtag_pkg;

  //////////////////////////////////////////////////
  // Instruction register
  //////////////////////////////////////////////////
  localparam int IR_LEN = 4;

  localparam logic [IR_LEN-1:0] OP_EXTEST = 4'b0000;  // Pins driven from the boundary chain
  localparam logic [IR_LEN-1:0] OP_SAMPLE = 4'b0001;  // SAMPLE_PRELOAD
  localparam logic [IR_LEN-1:0] OP_IDCODE = 4'b0010;  // Selected in Test-Logic-Reset
  localparam logic [IR_LEN-1:0] OP_DEBUG  = 4'b1000;  // 24-bit debug command chain
  localparam logic [IR_LEN-1:0] OP_MBIST  = 4'b1001;  // External MBIST chain
  localparam logic [IR_LEN-1:0] OP_BYPASS = 4'b1111;

  // Loaded at Capture-IR, low bits 01 as the standard asks
  localparam logic [IR_LEN-1:0] IR_CAPTURE = 4'b0101;

  //////////////////////////////////////////////////
  // Chain layouts
  //////////////////////////////////////////////////
  localparam int NUM_PINS = 8;

  // Data register strobes, one-hot TAP states
  typedef struct packed {
    logic capture_dr;
    logic shift_dr;
    logic pause_dr;
    logic update_dr;
  } tap_dr_t;

  // Boundary payload, core_out sits in the low bits and leaves first
  typedef struct packed {
    logic [NUM_PINS-1:0] pad_in;
    logic [NUM_PINS-1:0] core_out;
  } bsr_t;

  // Debug command in, debug status out
  typedef struct packed {
    logic [7:0]  addr;
    logic [15:0] data;
  } dbg_t;

endpackage

//--- source/jtag_scan_reg.sv
// Needs payload_t of at least 2 bits; captures, shifts and updates only while select_i is high
`timescale 1ns/1ps

module jtag_scan_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  logic              tck_pad_i,
  input  logic              trst_pad_i,
  input  logic              tdi_i,
  input  jtag_pkg::tap_dr_t dr_i,
  input  logic              select_i,         // Chain owns the DR path
  input  payload_t          capture_i,        // Loaded at Capture-DR
  output logic              tdo_o,            // Retimed on the falling edge
  output payload_t          update_o,
  output logic              update_strobe_o   // One tck wide
);

  localparam int W = $bits(payload_t);

  logic [W-1:0] shift_q;

  // Shift register, toward bit 0
  always_ff @(posedge tck_pad_i) begin
    if (select_i & dr_i.capture_dr) begin
      shift_q <= capture_i;
    end else if (select_i & dr_i.shift_dr) begin
      shift_q <= {tdi_i, shift_q[W-1:1]};   // TDI enters at the top
    end
  end

  // Update register and its strobe
  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      update_o        <= '0;
      update_strobe_o <= 1'b0;
    end else begin
      update_strobe_o <= select_i & dr_i.update_dr;  // Update-DR lasts one cycle
      if (select_i & dr_i.update_dr) begin
        update_o <= payload_t'(shift_q);
      end
    end
  end

  // Bit 0 out half a cycle later
  always_ff @(negedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      tdo_o <= 1'b0;
    end else begin
      tdo_o <= shift_q[0];
    end
  end

endmodule

//--- source/jtag_boundary.sv
// Output cells only; pad_in is sampled but no input pins are overridden, no INTEST
`timescale 1ns/1ps

module jtag_boundary (
  input  logic                          tck_pad_i,
  input  logic                          trst_pad_i,
  input  logic                          tdi_i,
  input  jtag_pkg::tap_dr_t             dr_i,
  input  logic                          extest_select_i,
  input  logic                          sample_select_i,
  input  logic [jtag_pkg::NUM_PINS-1:0] pad_in_i,     // Pin levels seen at the pads
  input  logic [jtag_pkg::NUM_PINS-1:0] core_out_i,   // Functional core outputs
  output logic                          tdo_o,
  output logic [jtag_pkg::NUM_PINS-1:0] pad_out_o
);
  import jtag_pkg::*;

  bsr_t capture_w;
  bsr_t update_w;
  logic select_w;

  assign capture_w.pad_in   = pad_in_i;
  assign capture_w.core_out = core_out_i;

  assign select_w = extest_select_i | sample_select_i;  // Same cells for both

  //////////////////////////////////////////////////
  // Shared scan register
  //////////////////////////////////////////////////
  jtag_scan_reg #(
    .payload_t (bsr_t)
  ) bsr_chain (
    .tck_pad_i       (tck_pad_i),
    .trst_pad_i      (trst_pad_i),
    .tdi_i           (tdi_i),
    .dr_i            (dr_i),
    .select_i        (select_w),
    .capture_i       (capture_w),
    .tdo_o           (tdo_o),
    .update_o        (update_w),
    .update_strobe_o ()
  );

  // EXTEST hands the pins to the preloaded values
  assign pad_out_o = extest_select_i ? update_w.core_out : core_out_i;

endmodule

//--- source/jtag_tap_ctrl.sv
// IEEE 1149.1 TAP; IDCODE_VALUE bit 0 must be 1, TDO and its enable change on the falling edge
`timescale 1ns/1ps

module jtag_tap_ctrl #(
  parameter logic [31:0] IDCODE_VALUE = 32'h149511c3
) (
  input  logic              tck_pad_i,
  input  logic              trst_pad_i,       // Async, active high
  input  logic              tms_pad_i,
  input  logic              tdi_pad_i,
  output logic              tdo_pad_o,
  output logic              tdo_padoe_o,      // Pad driver enable
  output jtag_pkg::tap_dr_t dr_o,             // DR strobes to all chains
  output logic              extest_select_o,
  output logic              sample_select_o,
  output logic              debug_select_o,
  output logic              mbist_select_o,
  input  logic              bs_tdo_i,         // Boundary chain, falling-edge retimed
  input  logic              debug_tdo_i,      // Debug chain, falling-edge retimed
  input  logic              mbist_tdo_i       // External MBIST return
);
  import jtag_pkg::*;

  // One-hot state bit positions
  localparam int S_TLR  = 0;   // Test-Logic-Reset
  localparam int S_RTI  = 1;   // Run-Test/Idle
  localparam int S_SDR  = 2;
  localparam int S_CDR  = 3;
  localparam int S_SHDR = 4;
  localparam int S_E1DR = 5;
  localparam int S_PDR  = 6;
  localparam int S_E2DR = 7;
  localparam int S_UDR  = 8;
  localparam int S_SIR  = 9;
  localparam int S_CIR  = 10;
  localparam int S_SHIR = 11;
  localparam int S_E1IR = 12;
  localparam int S_PIR  = 13;
  localparam int S_E2IR = 14;
  localparam int S_UIR  = 15;

  logic [15:0]       st_q;
  logic [15:0]       st_nxt;
  logic [3:0]        tms_q;            // Last four TMS samples
  logic              tms_reset;
  logic [IR_LEN-1:0] ir_q;             // Instruction shift register
  logic [IR_LEN-1:0] latched_ir;       // Active instruction
  logic [IR_LEN-1:0] latched_ir_neg;
  logic              shift_ir_neg;
  logic              ir_tdo;
  logic [31:0]       idcode_q;
  logic              idcode_tdo;
  logic              bypass_q;
  logic              bypass_tdo;
  logic              idcode_select;

  //////////////////////////////////////////////////
  // TAP state machine
  //////////////////////////////////////////////////
  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      tms_q <= '0;
    end else begin
      tms_q <= {tms_q[2:0], tms_pad_i};
    end
  end

  assign tms_reset = (&tms_q) & tms_pad_i;  // Five ones in a row

  always_comb begin
    st_nxt[S_TLR]  =  tms_pad_i & (st_q[S_TLR] | st_q[S_SIR]);
    st_nxt[S_RTI]  = ~tms_pad_i & (st_q[S_TLR] | st_q[S_RTI] | st_q[S_UDR] | st_q[S_UIR]);
    st_nxt[S_SDR]  =  tms_pad_i & (st_q[S_RTI] | st_q[S_UDR] | st_q[S_UIR]);
    // DR column
    st_nxt[S_CDR]  = ~tms_pad_i & st_q[S_SDR];
    st_nxt[S_SHDR] = ~tms_pad_i & (st_q[S_CDR] | st_q[S_SHDR] | st_q[S_E2DR]);
    st_nxt[S_E1DR] =  tms_pad_i & (st_q[S_CDR] | st_q[S_SHDR]);
    st_nxt[S_PDR]  = ~tms_pad_i & (st_q[S_E1DR] | st_q[S_PDR]);
    st_nxt[S_E2DR] =  tms_pad_i & st_q[S_PDR];
    st_nxt[S_UDR]  =  tms_pad_i & (st_q[S_E1DR] | st_q[S_E2DR]);
    // IR column
    st_nxt[S_SIR]  =  tms_pad_i & st_q[S_SDR];
    st_nxt[S_CIR]  = ~tms_pad_i & st_q[S_SIR];
    st_nxt[S_SHIR] = ~tms_pad_i & (st_q[S_CIR] | st_q[S_SHIR] | st_q[S_E2IR]);
    st_nxt[S_E1IR] =  tms_pad_i & (st_q[S_CIR] | st_q[S_SHIR]);
    st_nxt[S_PIR]  = ~tms_pad_i & (st_q[S_E1IR] | st_q[S_PIR]);
    st_nxt[S_E2IR] =  tms_pad_i & st_q[S_PIR];
    st_nxt[S_UIR]  =  tms_pad_i & (st_q[S_E1IR] | st_q[S_E2IR]);
  end

  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      st_q <= 16'(1) << S_TLR;
    end else if (tms_reset) begin
      st_q <= 16'(1) << S_TLR;   // Forced, whatever state we were in
    end else begin
      st_q <= st_nxt;
    end
  end

  assign dr_o.capture_dr = st_q[S_CDR];
  assign dr_o.shift_dr   = st_q[S_SHDR];
  assign dr_o.pause_dr   = st_q[S_PDR];
  assign dr_o.update_dr  = st_q[S_UDR];

  //////////////////////////////////////////////////
  // Instruction, IDCODE and bypass registers
  //////////////////////////////////////////////////
  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      ir_q <= '0;
    end else if (st_q[S_CIR]) begin
      ir_q <= IR_CAPTURE;                      // Fixed pattern for fault detection
    end else if (st_q[S_SHIR]) begin
      ir_q <= {tdi_pad_i, ir_q[IR_LEN-1:1]};   // LSB leaves first
    end
  end

  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      latched_ir <= OP_IDCODE;
    end else if (tms_reset | st_q[S_TLR]) begin
      latched_ir <= OP_IDCODE;
    end else if (st_q[S_UIR]) begin
      latched_ir <= ir_q;   // Takes effect leaving Update-IR
    end
  end

  // Reloads whenever it is not shifting
  always_ff @(posedge tck_pad_i) begin
    if (idcode_select & st_q[S_SHDR]) begin
      idcode_q <= {tdi_pad_i, idcode_q[31:1]};
    end else begin
      idcode_q <= IDCODE_VALUE;
    end
  end

  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      bypass_q <= 1'b0;
    end else if (st_q[S_CDR]) begin
      bypass_q <= 1'b0;   // Bypass stream starts with a zero
    end else if (st_q[S_SHDR]) begin
      bypass_q <= tdi_pad_i;
    end
  end

  //////////////////////////////////////////////////
  // Decode and TDO
  //////////////////////////////////////////////////
  always_comb begin
    extest_select_o = 1'b0;
    sample_select_o = 1'b0;
    idcode_select   = 1'b0;
    debug_select_o  = 1'b0;
    mbist_select_o  = 1'b0;
    case (latched_ir)
      OP_EXTEST: extest_select_o = 1'b1;
      OP_SAMPLE: sample_select_o = 1'b1;
      OP_IDCODE: idcode_select   = 1'b1;
      OP_DEBUG:  debug_select_o  = 1'b1;
      OP_MBIST:  mbist_select_o  = 1'b1;
      default:   ;                         // BYPASS and unknown codes
    endcase
  end

  // Falling-edge copies, so TDO is stable at the next rising edge
  always_ff @(negedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      shift_ir_neg   <= 1'b0;
      latched_ir_neg <= OP_IDCODE;
      ir_tdo         <= 1'b0;
      idcode_tdo     <= 1'b0;
      bypass_tdo     <= 1'b0;
      tdo_padoe_o    <= 1'b0;
    end else begin
      shift_ir_neg   <= st_q[S_SHIR];
      latched_ir_neg <= latched_ir;
      ir_tdo         <= ir_q[0];
      idcode_tdo     <= idcode_q[0];
      bypass_tdo     <= bypass_q;
      tdo_padoe_o    <= st_q[S_SHIR] | st_q[S_SHDR] | (st_q[S_PDR] & debug_select_o);
    end
  end

  always_comb begin
    if (shift_ir_neg) begin
      tdo_pad_o = ir_tdo;
    end else begin
      case (latched_ir_neg)
        OP_IDCODE: tdo_pad_o = idcode_tdo;
        OP_EXTEST: tdo_pad_o = bs_tdo_i;
        OP_SAMPLE: tdo_pad_o = bs_tdo_i;
        OP_DEBUG:  tdo_pad_o = debug_tdo_i;
        OP_MBIST:  tdo_pad_o = mbist_tdo_i;
        default:   tdo_pad_o = bypass_tdo;
      endcase
    end
  end

endmodule

//--- source/jtag_top.sv
// All logic runs on tck_pad_i; dbg_cmd_o holds until the next DEBUG update, MBIST chain is external
`timescale 1ns/1ps

module jtag_top #(
  parameter logic [31:0] IDCODE_VALUE = 32'h149511c3
) (
  input  logic                          tck_pad_i,
  input  logic                          trst_pad_i,
  input  logic                          tms_pad_i,
  input  logic                          tdi_pad_i,
  output logic                          tdo_pad_o,
  output logic                          tdo_padoe_o,
  output logic                          tdo_o,          // TDI passed on to the MBIST chain
  input  logic [jtag_pkg::NUM_PINS-1:0] pad_in_i,
  input  logic [jtag_pkg::NUM_PINS-1:0] core_out_i,
  output logic [jtag_pkg::NUM_PINS-1:0] pad_out_o,
  output logic                          mbist_select_o,
  input  logic                          mbist_tdo_i,
  input  jtag_pkg::dbg_t                dbg_status_i,   // Captured by DEBUG
  output jtag_pkg::dbg_t                dbg_cmd_o,
  output logic                          dbg_strobe_o    // New dbg_cmd_o
);
  import jtag_pkg::*;

  tap_dr_t dr_w;
  logic    extest_sel;
  logic    sample_sel;
  logic    debug_sel;
  logic    bs_tdo;
  logic    debug_tdo;

  assign tdo_o = tdi_pad_i;

  jtag_tap_ctrl #(
    .IDCODE_VALUE (IDCODE_VALUE)
  ) tap_ctrl (
    .tck_pad_i       (tck_pad_i),
    .trst_pad_i      (trst_pad_i),
    .tms_pad_i       (tms_pad_i),
    .tdi_pad_i       (tdi_pad_i),
    .tdo_pad_o       (tdo_pad_o),
    .tdo_padoe_o     (tdo_padoe_o),
    .dr_o            (dr_w),
    .extest_select_o (extest_sel),
    .sample_select_o (sample_sel),
    .debug_select_o  (debug_sel),
    .mbist_select_o  (mbist_select_o),
    .bs_tdo_i        (bs_tdo),
    .debug_tdo_i     (debug_tdo),
    .mbist_tdo_i     (mbist_tdo_i)
  );

  jtag_boundary boundary (
    .tck_pad_i       (tck_pad_i),
    .trst_pad_i      (trst_pad_i),
    .tdi_i           (tdi_pad_i),
    .dr_i            (dr_w),
    .extest_select_i (extest_sel),
    .sample_select_i (sample_sel),
    .pad_in_i        (pad_in_i),
    .core_out_i      (core_out_i),
    .tdo_o           (bs_tdo),
    .pad_out_o       (pad_out_o)
  );

  // Status out, command in, one strobe per update
  jtag_scan_reg #(
    .payload_t (dbg_t)
  ) debug_chain (
    .tck_pad_i       (tck_pad_i),
    .trst_pad_i      (trst_pad_i),
    .tdi_i           (tdi_pad_i),
    .dr_i            (dr_w),
    .select_i        (debug_sel),
    .capture_i       (dbg_status_i),
    .tdo_o           (debug_tdo),
    .update_o        (dbg_cmd_o),
    .update_strobe_o (dbg_strobe_o)
  );

endmodule

//--- verif/jtag_props.sv
// Bound into jtag_top; reads the Shift-IR bit of tap_ctrl's one-hot state, counts failures in fail_cnt
`timescale 1ns/1ps

module jtag_props (
  input logic                          tck_pad_i,
  input logic                          trst_pad_i,
  input jtag_pkg::tap_dr_t             dr_i,
  input logic                          shift_ir_i,
  input logic                          debug_select_i,
  input logic                          extest_select_i,
  input logic                          tdo_padoe_i,
  input logic                          dbg_strobe_i,
  input logic [jtag_pkg::NUM_PINS-1:0] pad_out_i,
  input logic [jtag_pkg::NUM_PINS-1:0] core_out_i
);

  int fail_cnt = 0;   // Read by the testbench at the end

  //////////////////////////////////////////////////
  // TDO driver, debug strobe, pin override
  //////////////////////////////////////////////////
  // Enable was set on the falling edge from the state still held here
  padoe_states: assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    tdo_padoe_i == (shift_ir_i | dr_i.shift_dr | (dr_i.pause_dr & debug_select_i)))
    else begin
      $error("TDO driver enable does not match Shift-IR, Shift-DR or debug Pause-DR");
      fail_cnt++;
    end

  strobe_single: assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    dbg_strobe_i |=> !dbg_strobe_i)   // One cycle only
    else begin
      $error("dbg_strobe_o held for two cycles");
      fail_cnt++;
    end

  pins_functional: assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    !extest_select_i |-> (pad_out_i == core_out_i))
    else begin
      $error("pad_out_o differs from core_out_i without EXTEST");
      fail_cnt++;
    end

endmodule

bind jtag_top jtag_props props (
  .tck_pad_i       (tck_pad_i),
  .trst_pad_i      (trst_pad_i),
  .dr_i            (dr_w),
  .shift_ir_i      (tap_ctrl.st_q[11]),   // Shift-IR state bit
  .debug_select_i  (debug_sel),
  .extest_select_i (extest_sel),
  .tdo_padoe_i     (tdo_padoe_o),
  .dbg_strobe_i    (dbg_strobe_o),
  .pad_out_i       (pad_out_o),
  .core_out_i      (core_out_i)
);

//--- verif/jtag_tb.sv
// TDI stream comes from a fixed-seed LFSR; expects IDCODE 149511c3 and ends by a cycle-budget watchdog
`timescale 1ns/1ps

module jtag_tb;
  import jtag_pkg::*;

  localparam logic [31:0] IDCODE_VALUE = 32'h149511c3;
  // TCK cycles for reset and each test
  localparam int TEST_CYCLES = 3 + 91 + 31 + 31 + 21 + 71 + 33;
  localparam int WATCHDOG_NS = TEST_CYCLES * 10 * 3 / 2;   // Plus half again

  logic                tck_pad_i;
  logic                trst_pad_i;
  logic                tms_pad_i;
  logic                tdi_pad_i;
  logic                tdo_pad_o;
  logic                tdo_padoe_o;
  logic                tdo_o;
  logic [NUM_PINS-1:0] pad_in_i;
  logic [NUM_PINS-1:0] core_out_i;
  logic [NUM_PINS-1:0] pad_out_o;
  logic                mbist_select_o;
  logic                mbist_tdo_i;
  dbg_t                dbg_status_i;
  dbg_t                dbg_cmd_o;
  logic                dbg_strobe_o;

  logic [15:0] lfsr_q = 16'd44;   // Seed
  int          err_cnt = 0;
  int          errs_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          strobe_cnt = 0;   // dbg_strobe_o cycles seen

  jtag_top #(.IDCODE_VALUE(IDCODE_VALUE)) dut_i (.*);

  initial begin : clock_gen
    tck_pad_i = 1'b0;
    forever #5 tck_pad_i = ~tck_pad_i;
  end

  always @(posedge tck_pad_i) begin
    if (dbg_strobe_o) begin
      strobe_cnt++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  function automatic logic lfsr_bit();
    logic out_bit;
    out_bit = lfsr_q[0];
    lfsr_q  = {1'b0, lfsr_q[15:1]} ^ (out_bit ? 16'hB400 : 16'h0000);   // Galois taps
    return out_bit;
  endfunction

  function automatic logic [31:0] rand_word(input int n);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < n; i++) w[i] = lfsr_bit();   // One step per bit
    return w;
  endfunction

  // Called at posedge+1; TDO sampled just after the falling edge
  task automatic tck_step(input logic tms, input logic tdi, output logic tdo);
    tms_pad_i = tms;
    tdi_pad_i = tdi;
    @(negedge tck_pad_i);
    #1;
    tdo = tdo_pad_o;
    check(tdo_o == tdi, "tdo_o does not pass tdi_pad_i through");
    @(posedge tck_pad_i);
    #1;
  endtask

  task automatic tms_step(input logic tms);
    logic tdo_unused;
    tck_step(tms, 1'b0, tdo_unused);
  endtask

  task automatic goto_reset();
    repeat (5) tms_step(1'b1);   // Test-Logic-Reset from anywhere
    tms_step(1'b0);              // Run-Test/Idle
  endtask

  // From Run-Test/Idle back to Run-Test/Idle
  task automatic load_ir(input logic [IR_LEN-1:0] op, output logic [IR_LEN-1:0] captured);
    tms_step(1'b1);   // Select-DR
    tms_step(1'b1);   // Select-IR
    tms_step(1'b0);   // Capture-IR
    tms_step(1'b0);   // Shift-IR
    for (int i = 0; i < IR_LEN; i++) tck_step(i == IR_LEN - 1, op[i], captured[i]);
    tms_step(1'b1);   // Update-IR
    tms_step(1'b0);   // Instruction live on this edge
  endtask

  task automatic shift_dr(input int n, input logic [31:0] din, output logic [31:0] dout);
    dout = '0;
    tms_step(1'b1);   // Select-DR
    tms_step(1'b0);   // Capture-DR
    tms_step(1'b0);   // Shift-DR
    for (int i = 0; i < n; i++) tck_step(i == n - 1, din[i], dout[i]);   // LSB first
    tms_step(1'b1);   // Update-DR
    tms_step(1'b0);   // Update lands here
  endtask

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("Error %0t: %s", $time, msg);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == errs_at_start) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, err_cnt - errs_at_start);
    end
    errs_at_start = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  initial begin : run_tests
    logic [31:0]       din;
    logic [31:0]       dout;
    logic [31:0]       w;
    logic [IR_LEN-1:0] cap;
    int                strobes_before;
    dbg_t              cmd_before;
    trst_pad_i   = 1'b1;
    tms_pad_i    = 1'b1;
    tdi_pad_i    = 1'b0;
    pad_in_i     = '0;
    core_out_i   = '0;
    mbist_tdo_i  = 1'b0;
    dbg_status_i = '0;
    repeat (3) @(posedge tck_pad_i);
    #1;
    trst_pad_i = 1'b0;

    tms_step(1'b0);   // Leave Test-Logic-Reset
    shift_dr(32, rand_word(32), dout);
    check(dout == IDCODE_VALUE, $sformatf("IDCODE after trst read %h", dout));
    load_ir(OP_BYPASS, cap);
    goto_reset();   // IDCODE again whatever was latched
    shift_dr(32, rand_word(32), dout);
    check(dout == IDCODE_VALUE, $sformatf("IDCODE after TMS reset read %h", dout));
    end_test("idcode");

    load_ir(OP_BYPASS, cap);
    check(cap == 4'b0101, $sformatf("IR capture read %b, expected 0101", cap));
    din = rand_word(16);
    shift_dr(16, din, dout);
    check(dout[15:0] == {din[14:0], 1'b0}, $sformatf("bypass stream %h for tdi %h",
          dout[15:0], din[15:0]));
    end_test("bypass");

    w          = rand_word(16);
    pad_in_i   = w[15:8];
    core_out_i = w[7:0];
    load_ir(OP_SAMPLE, cap);
    din = rand_word(16);   // Doubles as the EXTEST preload
    shift_dr(16, din, dout);
    check(dout[15:0] == {pad_in_i, core_out_i}, $sformatf("sample read %h", dout[15:0]));
    end_test("sample_preload");

    load_ir(OP_EXTEST, cap);
    check(pad_out_o == din[7:0], $sformatf("EXTEST pad_out_o %h, expected %h",
          pad_out_o, din[7:0]));
    core_out_i = ~core_out_i;
    tms_step(1'b0);
    check(pad_out_o == din[7:0], "pad_out_o followed core_out_i under EXTEST");
    load_ir(OP_BYPASS, cap);
    check(pad_out_o == core_out_i, "pad_out_o did not return to core_out_i after EXTEST");
    end_test("extest");

    w            = rand_word(24);
    dbg_status_i = w[23:0];
    load_ir(OP_DEBUG, cap);
    strobes_before = strobe_cnt;
    din = rand_word(24);
    shift_dr(24, din, dout);
    check(dout[23:0] == dbg_status_i, $sformatf("debug status read %h", dout[23:0]));
    check(dbg_cmd_o == din[23:0], $sformatf("dbg_cmd_o %h, expected %h", dbg_cmd_o, din[23:0]));
    tms_step(1'b0);
    check(strobe_cnt == strobes_before + 1, "dbg_strobe_o did not pulse once after Update-DR");
    cmd_before = dbg_cmd_o;
    load_ir(4'b0111, cap);   // Undefined code
    din = rand_word(16);
    shift_dr(16, din, dout);
    check(dout[15:0] == {din[14:0], 1'b0}, $sformatf("opcode 0111 stream %h", dout[15:0]));
    check(dbg_cmd_o == cmd_before && strobe_cnt == strobes_before + 1,
          "opcode 0111 disturbed the debug chain");
    end_test("debug");

    mbist_tdo_i = 1'b1;   // External chain returns ones
    load_ir(OP_MBIST, cap);
    check(mbist_select_o, "mbist_select_o low with MBIST latched");
    din = rand_word(8);
    shift_dr(8, din, dout);
    check(dout[7:0] == 8'hff, $sformatf("MBIST return stream %h, expected ff", dout[7:0]));
    mbist_tdo_i = 1'b0;
    load_ir(OP_BYPASS, cap);
    check(!mbist_select_o, "mbist_select_o still high after BYPASS");
    end_test("mbist");

    $display("Tests run %0d, failed %0d, check errors %0d, property failures %0d",
             tests_run, tests_failed, err_cnt, dut_i.props.fail_cnt);
    if (err_cnt == 0 && dut_i.props.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the TAP sequence never finished", WATCHDOG_NS);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- sim.f
source/jtag_pkg.sv
source/jtag_scan_reg.sv
source/jtag_boundary.sv
source/jtag_tap_ctrl.sv
source/jtag_top.sv
verif/jtag_props.sv
verif/jtag_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = jtag_tb
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
